// File: Makefile
# Verilator build and run for the uart_periph testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal -f uart_periph.f \
		--top-module uart_periph_tb -Mdir obj_dir -o uart_periph_sim
	./obj_dir/uart_periph_sim | tee $(LOG)
	@if grep -q "TESTS PASSED" $(LOG); then \
		echo "result: pass"; \
	else \
		echo "result: fail"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// File: src/uart_line_pkg.sv
package uart_line_pkg;

    // serial frame layout, 8N1
    localparam int DATA_BITS = 8;

    // start + data + stop
    localparam int FRAME_BITS = DATA_BITS + 2;

    // default counter width for the bit timing
    localparam int DIV_WIDTH_DEFAULT = 16;

    // divisor loaded into the baud register at reset
    // one bit period lasts divisor + 1 clock cycles
    localparam logic [31:0] BAUD_DIV_DEFAULT = 32'd15;

endpackage

// File: src/uart_periph.sv
module uart_periph
    import uart_line_pkg::*;
#(
    parameter int          DIV_WIDTH      = DIV_WIDTH_DEFAULT,
    parameter logic [31:0] BAUD_DIV_RESET = BAUD_DIV_DEFAULT
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        we_i,
    input  logic [7:0]  addr_i,
    input  logic [31:0] data_i,
    output logic [31:0] data_o,
    output logic        tx_o,
    input  logic        rx_i
);

    // register block to transmitter
    logic                 tx_valid;
    logic [DATA_BITS-1:0] tx_data;
    logic                 tx_credit;

    // receiver to register block
    logic                 rx_en;
    logic                 rx_valid;
    logic [DATA_BITS-1:0] rx_data;

    // shared bit timing
    logic [DIV_WIDTH-1:0] baud_div;

    uart_regs #(
        .DIV_WIDTH      (DIV_WIDTH),
        .BAUD_DIV_RESET (BAUD_DIV_RESET)
    ) uart_regs_i (
        .clk         (clk),
        .rst         (rst),
        .we_i        (we_i),
        .addr_i      (addr_i),
        .data_i      (data_i),
        .data_o      (data_o),
        .tx_valid_o  (tx_valid),
        .tx_data_o   (tx_data),
        .tx_credit_i (tx_credit),
        .rx_en_o     (rx_en),
        .rx_valid_i  (rx_valid),
        .rx_data_i   (rx_data),
        .baud_div_o  (baud_div)
    );

    uart_tx #(
        .DIV_WIDTH (DIV_WIDTH)
    ) uart_tx_i (
        .clk         (clk),
        .rst         (rst),
        .baud_div_i  (baud_div),
        .tx_valid_i  (tx_valid),
        .tx_data_i   (tx_data),
        .tx_credit_o (tx_credit),
        .tx_o        (tx_o)
    );

    uart_rx #(
        .DIV_WIDTH (DIV_WIDTH)
    ) uart_rx_i (
        .clk        (clk),
        .rst        (rst),
        .baud_div_i (baud_div),
        .rx_en_i    (rx_en),
        .rx_i       (rx_i),
        .rx_valid_o (rx_valid),
        .rx_data_o  (rx_data)
    );

endmodule

// File: src/uart_reg_pkg.sv
package uart_reg_pkg;

    // bus data width
    localparam int BUS_WIDTH = 32;

    // register offsets, low eight address bits
    localparam logic [7:0] ADDR_CTRL   = 8'h00;
    localparam logic [7:0] ADDR_STATUS = 8'h04;
    localparam logic [7:0] ADDR_BAUD   = 8'h08;
    localparam logic [7:0] ADDR_TXDATA = 8'h0C;
    localparam logic [7:0] ADDR_RXDATA = 8'h10;

    // control register fields
    localparam int CTRL_TX_EN = 0;
    localparam int CTRL_RX_EN = 1;

    // status register fields
    // busy is read only, full is cleared by software
    localparam int STAT_TX_BUSY = 0;
    localparam int STAT_RX_FULL = 1;

endpackage

// File: src/uart_regs.sv
module uart_regs
    import uart_line_pkg::*;
    import uart_reg_pkg::*;
#(
    parameter int          DIV_WIDTH      = 16,
    parameter logic [31:0] BAUD_DIV_RESET = 32'd15
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 we_i,
    input  logic [7:0]           addr_i,
    input  logic [BUS_WIDTH-1:0] data_i,
    output logic [BUS_WIDTH-1:0] data_o,
    output logic                 tx_valid_o,
    output logic [DATA_BITS-1:0] tx_data_o,
    input  logic                 tx_credit_i,
    output logic                 rx_en_o,
    input  logic                 rx_valid_i,
    input  logic [DATA_BITS-1:0] rx_data_i,
    output logic [DIV_WIDTH-1:0] baud_div_o
);

    logic                 tx_en_q;
    logic                 rx_en_q;
    logic [BUS_WIDTH-1:0] baud_q;
    logic                 credit_q;
    logic                 rx_full_q;
    logic [DATA_BITS-1:0] rx_data_q;
    logic                 wr_ctrl;
    logic                 wr_status;
    logic                 wr_baud;
    logic                 tx_accept;

    // write decode
    assign wr_ctrl   = we_i && (addr_i == ADDR_CTRL);
    assign wr_status = we_i && (addr_i == ADDR_STATUS);
    assign wr_baud   = we_i && (addr_i == ADDR_BAUD);

    // a byte is taken only with tx enabled and the credit in hand
    assign tx_accept = we_i && (addr_i == ADDR_TXDATA) && tx_en_q && credit_q;

    always_ff @(posedge clk) begin
        if (!rst) begin
            tx_en_q <= 1'b0;
            rx_en_q <= 1'b0;
            baud_q  <= BAUD_DIV_RESET;
        end else begin
            if (wr_ctrl) begin
                tx_en_q <= data_i[CTRL_TX_EN];
                rx_en_q <= data_i[CTRL_RX_EN];
            end
            if (wr_baud) begin
                baud_q <= data_i;
            end
        end
    end

    // single transmit credit, spent on launch and returned after the stop bit
    always_ff @(posedge clk) begin
        if (!rst) begin
            credit_q   <= 1'b1;
            tx_valid_o <= 1'b0;
        end else begin
            tx_valid_o <= tx_accept;
            if (tx_accept) begin
                credit_q <= 1'b0;
            end else if (tx_credit_i) begin
                credit_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tx_accept) begin
            tx_data_o <= data_i[DATA_BITS-1:0];
        end
    end

    // receive capture, a new byte wins over a software clear
    always_ff @(posedge clk) begin
        if (!rst) begin
            rx_full_q <= 1'b0;
            rx_data_q <= '0;
        end else begin
            if (rx_valid_i) begin
                rx_full_q <= 1'b1;
                rx_data_q <= rx_data_i;
            end else if (wr_status) begin
                rx_full_q <= data_i[STAT_RX_FULL];
            end
        end
    end

    assign rx_en_o    = rx_en_q;
    assign baud_div_o = baud_q[DIV_WIDTH-1:0];

    // read mux, unmapped offsets return zero
    always_comb begin
        data_o = '0;
        case (addr_i)
            ADDR_CTRL: begin
                data_o[CTRL_TX_EN] = tx_en_q;
                data_o[CTRL_RX_EN] = rx_en_q;
            end
            ADDR_STATUS: begin
                data_o[STAT_TX_BUSY] = !credit_q;
                data_o[STAT_RX_FULL] = rx_full_q;
            end
            ADDR_BAUD:   data_o = baud_q;
            ADDR_RXDATA: data_o[DATA_BITS-1:0] = rx_data_q;
            default:     data_o = '0;
        endcase
    end

endmodule

// File: src/uart_rx.sv
module uart_rx
    import uart_line_pkg::*;
#(
    parameter int DIV_WIDTH = 16
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [DIV_WIDTH-1:0] baud_div_i,
    input  logic                 rx_en_i,
    input  logic                 rx_i,
    output logic                 rx_valid_o,
    output logic [DATA_BITS-1:0] rx_data_o
);

    localparam int BIT_W = $clog2(FRAME_BITS);

    typedef enum logic [1:0] {
        S_IDLE,
        S_START,
        S_DATA,
        S_STOP
    } state_t;

    state_t               state;
    logic                 sync_q0;
    logic                 sync_q1;
    logic                 line_prev;
    logic                 start_edge;
    logic [DIV_WIDTH-1:0] cycle_cnt;
    logic [DIV_WIDTH:0]   half_bit;
    logic                 half_done;
    logic                 period_end;
    logic [BIT_W-1:0]     bit_cnt;
    logic [DATA_BITS-1:0] shift_q;

    // two-flop synchronizer plus one flop for edge detection
    // idle line is high, so these come out of reset high
    always_ff @(posedge clk) begin
        if (!rst) begin
            sync_q0   <= 1'b1;
            sync_q1   <= 1'b1;
            line_prev <= 1'b1;
        end else begin
            sync_q0   <= rx_i;
            sync_q1   <= sync_q0;
            line_prev <= sync_q1;
        end
    end

    assign start_edge = line_prev && !sync_q1;

    // B/2 rounded down, with B = divisor + 1
    assign half_bit   = ({1'b0, baud_div_i} + 1'b1) >> 1;
    assign half_done  = ({1'b0, cycle_cnt} + 1'b1) >= half_bit;
    assign period_end = (cycle_cnt == baud_div_i);

    always_ff @(posedge clk) begin
        if (!rst) begin
            state      <= S_IDLE;
            cycle_cnt  <= '0;
            bit_cnt    <= '0;
            rx_valid_o <= 1'b0;
        end else begin
            rx_valid_o <= 1'b0;
            cycle_cnt  <= cycle_cnt + 1'b1;
            if (!rx_en_i) begin
                // disabling the receiver drops any frame in flight
                state     <= S_IDLE;
                cycle_cnt <= '0;
            end else begin
                case (state)
                    S_IDLE: begin
                        cycle_cnt <= '0;
                        if (start_edge) begin
                            state <= S_START;
                        end
                    end
                    S_START: begin
                        if (half_done) begin
                            cycle_cnt <= '0;
                            bit_cnt   <= '0;
                            // glitch, not a real start bit
                            state     <= sync_q1 ? S_IDLE : S_DATA;
                        end
                    end
                    S_DATA: begin
                        if (period_end) begin
                            cycle_cnt <= '0;
                            bit_cnt   <= bit_cnt + 1'b1;
                            if (bit_cnt == BIT_W'(DATA_BITS - 1)) begin
                                rx_valid_o <= 1'b1;
                                state      <= S_STOP;
                            end
                        end
                    end
                    S_STOP: begin
                        // hold off until the middle of the stop bit
                        if (period_end) begin
                            cycle_cnt <= '0;
                            state     <= S_IDLE;
                        end
                    end
                    default: state <= S_IDLE;
                endcase
            end
        end
    end

    // mid-bit samples enter at the top, lsb ends up in bit 0
    always_ff @(posedge clk) begin
        if (state == S_DATA && period_end) begin
            shift_q <= {sync_q1, shift_q[DATA_BITS-1:1]};
        end
    end

    assign rx_data_o = shift_q;

endmodule

// File: src/uart_tx.sv
module uart_tx
    import uart_line_pkg::*;
#(
    parameter int DIV_WIDTH = 16
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [DIV_WIDTH-1:0] baud_div_i,
    input  logic                 tx_valid_i,
    input  logic [DATA_BITS-1:0] tx_data_i,
    output logic                 tx_credit_o,
    output logic                 tx_o
);

    localparam int BIT_W = $clog2(FRAME_BITS);

    typedef enum logic [1:0] {
        S_IDLE,
        S_START,
        S_DATA,
        S_STOP
    } state_t;

    state_t               state;
    logic [DIV_WIDTH-1:0] cycle_cnt;
    logic [BIT_W-1:0]     bit_cnt;
    logic [DATA_BITS-1:0] shift_q;
    logic                 period_end;

    // last cycle of the current bit period
    assign period_end = (cycle_cnt == baud_div_i);

    always_ff @(posedge clk) begin
        if (!rst) begin
            state       <= S_IDLE;
            cycle_cnt   <= '0;
            bit_cnt     <= '0;
            tx_o        <= 1'b1;
            tx_credit_o <= 1'b0;
        end else begin
            tx_credit_o <= 1'b0;
            if (state == S_IDLE) begin
                cycle_cnt <= '0;
                if (tx_valid_i) begin
                    // start bit goes out right away
                    state   <= S_START;
                    bit_cnt <= '0;
                    tx_o    <= 1'b0;
                end
            end else if (!period_end) begin
                cycle_cnt <= cycle_cnt + 1'b1;
            end else begin
                cycle_cnt <= '0;
                case (state)
                    S_START: begin
                        tx_o  <= shift_q[0];
                        state <= S_DATA;
                    end
                    S_DATA: begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == BIT_W'(DATA_BITS - 1)) begin
                            tx_o  <= 1'b1;
                            state <= S_STOP;
                        end else begin
                            tx_o <= shift_q[0];
                        end
                    end
                    S_STOP: begin
                        // frame slot free again, hand the credit back
                        tx_credit_o <= 1'b1;
                        state       <= S_IDLE;
                    end
                    default: state <= S_IDLE;
                endcase
            end
        end
    end

    // byte latch, shifted out lsb first
    always_ff @(posedge clk) begin
        if (state == S_IDLE && tx_valid_i) begin
            shift_q <= tx_data_i;
        end else if (period_end && (state == S_START || state == S_DATA)) begin
            shift_q <= shift_q >> 1;
        end
    end

endmodule

// File: tb/uart_tb_tasks.svh
`ifndef UART_TB_TASKS_SVH
`define UART_TB_TASKS_SVH

// report the error and end the run
task automatic abort_run(input string why);
    $display("%s", why);
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped at first error");
endtask

task automatic check_value(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    if (got !== exp) begin
        abort_run($sformatf("CHECK FAILED at %0t: %s got 0x%0h, expected 0x%0h",
                            $time, name, got, exp));
    end
endtask

task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
    @(posedge clk);
    #2;
    we_i   = 1'b1;
    addr_i = addr;
    data_i = data;
    @(posedge clk);
    #2;
    we_i = 1'b0;
endtask

// read mux is combinational, sample half a cycle later
task automatic read_reg(input logic [7:0] addr, output logic [31:0] data);
    @(posedge clk);
    #2;
    addr_i = addr;
    @(negedge clk);
    data = data_o;
endtask

task automatic expect_reg(input logic [7:0] addr, input string name,
                          input logic [31:0] exp);
    logic [31:0] rd;
    read_reg(addr, rd);
    check_value(name, rd, exp);
endtask

// poll STATUS until one bit reaches a value
task automatic wait_status(input int idx, input logic value);
    logic [31:0] rd;
    int          n;
    n = 0;
    read_reg(ADDR_STATUS, rd);
    while (rd[idx] !== value) begin
        n++;
        if (n > WAIT_LIMIT) begin
            abort_run($sformatf("timeout: STATUS bit %0d never read %0b", idx, value));
        end
        read_reg(ADDR_STATUS, rd);
    end
endtask

// serial driver, each bit held for bt cycles
task automatic drive_frame(input logic [7:0] data, input int bt);
    logic [9:0] frame;
    frame = frame_bits(data);
    for (int i = 0; i < FRAME_BITS; i++) begin
        @(posedge clk);
        #2;
        rx_i = frame[i];
        repeat (bt - 1) @(posedge clk);
    end
    @(posedge clk);
endtask

// serial monitor, samples each bit in the middle of its period
task automatic monitor_frame(input logic [7:0] data, input int bt);
    logic [9:0] frame;
    int         n;
    frame = frame_bits(data);
    n = 0;
    @(negedge clk);
    while (tx_o !== 1'b0) begin
        n++;
        if (n > WAIT_LIMIT) begin
            abort_run("timeout: no start bit appeared on tx_o");
        end
        @(negedge clk);
    end
    repeat (bt / 2) @(negedge clk);
    for (int i = 0; i < FRAME_BITS; i++) begin
        check_value($sformatf("tx_o frame bit %0d", i), 32'(tx_o), 32'(frame[i]));
        if (i < FRAME_BITS - 1) begin
            repeat (bt) @(negedge clk);
        end
    end
endtask

task automatic expect_idle_line(input int cycles);
    repeat (cycles) begin
        @(negedge clk);
        check_value("tx_o idle", 32'(tx_o), 32'd1);
    end
endtask

`endif

// File: tb/uart_periph_tb.sv
module uart_periph_tb
    import uart_line_pkg::*;
    import uart_reg_pkg::*;
();

    // small reset divisor keeps frames short (B = 6)
    localparam logic [31:0] BAUD_RESET = 32'd5;
    localparam int          WAIT_LIMIT = 5000;

    logic        clk;
    logic        rst;
    logic        we_i;
    logic [7:0]  addr_i;
    logic [31:0] data_i;
    logic [31:0] data_o;
    logic        tx_o;
    logic        rx_i;

    // reference model state
    logic [31:0] m_ctrl;
    logic [31:0] m_baud;
    logic        m_credit;
    logic        m_rx_full;
    logic [7:0]  m_rx_data;

    uart_periph #(
        .DIV_WIDTH      (16),
        .BAUD_DIV_RESET (BAUD_RESET)
    ) uart_periph_i (
        .clk    (clk),
        .rst    (rst),
        .we_i   (we_i),
        .addr_i (addr_i),
        .data_i (data_i),
        .data_o (data_o),
        .tx_o   (tx_o),
        .rx_i   (rx_i)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // frame in line order with the start bit in bit 0 and data lsb first
    function automatic logic [9:0] frame_bits(input logic [7:0] data);
        return {1'b1, data, 1'b0};
    endfunction

    function automatic int bit_cycles();
        return int'(m_baud) + 1;
    endfunction

    function automatic logic [31:0] expected_status();
        return {30'd0, m_rx_full, !m_credit};
    endfunction

    `include "uart_tb_tasks.svh"

    task automatic set_ctrl(input logic [1:0] en);
        write_reg(ADDR_CTRL, {30'd0, en});
        m_ctrl = {30'd0, en};
        expect_reg(ADDR_CTRL, "CTRL", m_ctrl);
    endtask

    // one byte out with an optional second write while busy
    task automatic tx_frame(input logic [7:0] data, input logic poke);
        logic [31:0] rd;
        write_reg(ADDR_TXDATA, {24'd0, data});
        m_credit = 1'b0;
        fork
            monitor_frame(data, bit_cycles());
            begin
                read_reg(ADDR_STATUS, rd);
                check_value("STATUS tx busy", 32'(rd[STAT_TX_BUSY]), 32'(!m_credit));
                if (poke) begin
                    write_reg(ADDR_TXDATA, {24'd0, ~data});
                end
            end
        join
        wait_status(STAT_TX_BUSY, 1'b0);
        m_credit = 1'b1;
        // dropped byte must not show up later
        if (poke) begin
            expect_idle_line(FRAME_BITS * bit_cycles());
        end
    endtask

    task automatic rx_byte(input logic [7:0] data);
        drive_frame(data, bit_cycles());
        if (m_ctrl[CTRL_RX_EN]) begin
            m_rx_full = 1'b1;
            m_rx_data = data;
            wait_status(STAT_RX_FULL, 1'b1);
        end
        expect_reg(ADDR_STATUS, "STATUS", expected_status());
        expect_reg(ADDR_RXDATA, "RXDATA", {24'd0, m_rx_data});
        if (m_ctrl[CTRL_RX_EN]) begin
            write_reg(ADDR_STATUS, 32'd0);
            m_rx_full = 1'b0;
            expect_reg(ADDR_STATUS, "STATUS after clear", expected_status());
        end
    endtask

    initial begin
        void'($urandom(32'h6311));
        rst       = 1'b0;
        we_i      = 1'b0;
        addr_i    = 8'h00;
        data_i    = 32'd0;
        rx_i      = 1'b1;
        m_ctrl    = 32'd0;
        m_baud    = BAUD_RESET;
        m_credit  = 1'b1;
        m_rx_full = 1'b0;
        m_rx_data = 8'd0;
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b1;

        // reset values
        expect_reg(ADDR_CTRL, "CTRL", m_ctrl);
        expect_reg(ADDR_STATUS, "STATUS", expected_status());
        expect_reg(ADDR_BAUD, "BAUD", m_baud);
        expect_reg(ADDR_RXDATA, "RXDATA", 32'd0);
        expect_reg(8'h14, "unmapped 0x14", 32'd0);
        check_value("tx_o after reset", 32'(tx_o), 32'd1);

        // transmit then writes that must be dropped
        set_ctrl(2'b01);
        tx_frame(8'($urandom), 1'b0);
        tx_frame(8'($urandom), 1'b1);
        set_ctrl(2'b00);
        write_reg(ADDR_TXDATA, {24'd0, 8'($urandom)});
        expect_idle_line(FRAME_BITS * bit_cycles());
        expect_reg(ADDR_STATUS, "STATUS tx disabled", expected_status());

        // receive enabled then disabled
        set_ctrl(2'b10);
        repeat (3) rx_byte(8'($urandom));
        set_ctrl(2'b00);
        rx_byte(8'($urandom));

        // new bit period for both directions
        m_baud = 32'd3 + ($urandom % 6);
        write_reg(ADDR_BAUD, m_baud);
        expect_reg(ADDR_BAUD, "BAUD", m_baud);
        set_ctrl(2'b11);
        repeat (20) begin
            tx_frame(8'($urandom), 1'b0);
            rx_byte(8'($urandom));
        end

        $display("TESTS PASSED");
        $finish;
    end

endmodule

// File: uart_periph.f
+incdir+tb
src/uart_line_pkg.sv
src/uart_reg_pkg.sv
src/uart_tx.sv
src/uart_rx.sv
src/uart_regs.sv
src/uart_periph.sv
tb/uart_periph_tb.sv
